// File: src/arm_pkg.sv
package arm_pkg;

    // sequencer states, codes match the display digit
    typedef enum logic [3:0] {
        st_wait          = 4'd0,
        st_start         = 4'd1,
        st_right_waist   = 4'd2,
        st_left_waist    = 4'd3,
        st_middle_waist  = 4'd4,
        st_down_elbow    = 4'd5,
        st_up_elbow      = 4'd6,
        st_deliver_waist = 4'd7,
        st_close_claw    = 4'd8,
        st_open_claw     = 4'd9,
        st_deliver_elbow = 4'd11,
        st_settle        = 4'd12
    } arm_state_t;

    typedef logic [11:0] servo_width_t;   // pulse width in pwm steps

    localparam int PWM_FRAME_STEPS  = 2000;   // 20 ms frame at default step
    localparam int DEF_TICK_DIV     = 1000;   // clocks per step
    localparam int DEF_DWELL_FRAMES = 125;    // 2.5 s per move
    localparam int DEF_SCAN_BITS    = 18;

    localparam int NUM_TARGETS = 3;           // left, right, middle beacons

    // servo poses
    localparam servo_width_t W_WAIST_HOME    = 12'd150;
    localparam servo_width_t W_WAIST_LEFT    = 12'd70;
    localparam servo_width_t W_WAIST_RIGHT   = 12'd115;
    localparam servo_width_t W_WAIST_MIDDLE  = 12'd150;
    localparam servo_width_t W_WAIST_DELIVER = 12'd243;
    localparam servo_width_t W_ELBOW_HOME    = 12'd120;
    localparam servo_width_t W_ELBOW_RAISED  = 12'd150;
    localparam servo_width_t W_ELBOW_DOWN    = 12'd90;
    localparam servo_width_t W_ELBOW_UP      = 12'd190;
    localparam servo_width_t W_ELBOW_DELIVER = 12'd160;
    localparam servo_width_t W_CLAW_OPEN     = 12'd90;
    localparam servo_width_t W_CLAW_CLOSED   = 12'd210;

    // seven segment glyphs, gfedcba, segment on when low
    localparam int NUM_GLYPHS = 13;
    localparam logic [6:0] GLYPH_DASH = 7'b0111111;

    localparam logic [NUM_GLYPHS-1:0][6:0] GLYPH_HEX = {
        7'b1000110,   // C
        7'b0000011,   // b
        7'b0001000,   // A
        7'b0010000,   // 9
        7'b0000000,   // 8
        7'b1111000,   // 7
        7'b0000010,   // 6
        7'b0010010,   // 5
        7'b0011001,   // 4
        7'b0110000,   // 3
        7'b0100100,   // 2
        7'b1111001,   // 1
        7'b1000000    // 0
    };

endpackage

// File: src/servo_if.sv
`timescale 1ns/1ps

interface servo_if import arm_pkg::*; ();

    servo_width_t waist;   // pulse widths set by the sequencer
    servo_width_t elbow;
    servo_width_t claw;
    logic         frame_end;   // last clock of a pwm frame

    modport seq (
        output waist, elbow, claw,
        input  frame_end
    );

    modport pwm (
        input  waist, elbow, claw,
        output frame_end
    );

endinterface

// File: src/arm_sequencer.sv
`timescale 1ns/1ps

module arm_sequencer import arm_pkg::*; #(
    parameter int dwell_frames = DEF_DWELL_FRAMES
) (
    input  logic                   clk,
    input  logic                   clr,
    input  logic [NUM_TARGETS-1:0] ir,
    input  logic                   ir_arm,
    servo_if.seq                   servo,
    output arm_state_t             state
);

    typedef logic [$clog2(dwell_frames + 1) - 1:0] dwell_t;

    arm_state_t             state_next;
    dwell_t                 dwell_cnt;     // frame_end pulses since entry
    logic                   dwell_end;
    logic [NUM_TARGETS-1:0] served;
    logic                   claw_closed;
    logic [1:0]             tgt;           // beacon picked from ir
    logic                   tgt_valid;

    assign dwell_end = servo.frame_end && (dwell_cnt == dwell_t'(dwell_frames - 1));

    // lowest set ir bit wins
    always_comb
    begin
        tgt       = 2'd0;
        tgt_valid = 1'b1;
        if (ir[0])
            tgt = 2'd0;
        else if (ir[1])
            tgt = 2'd1;
        else if (ir[2])
            tgt = 2'd2;
        else
            tgt_valid = 1'b0;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            st_wait:
            begin
                if (ir_arm)
                    state_next = st_start;
            end
            st_start:
            begin
                if (tgt_valid && served[tgt])
                    state_next = st_wait;   // already delivered, no wait for dwell
                else if (tgt_valid && dwell_end)
                begin
                    case (tgt)
                        2'd0:    state_next = st_left_waist;
                        2'd1:    state_next = st_right_waist;
                        default: state_next = st_middle_waist;
                    endcase
                end
            end
            st_left_waist, st_right_waist:
            begin
                if (dwell_end)
                    state_next = st_settle;
            end
            st_settle, st_middle_waist:
            begin
                if (dwell_end)
                    state_next = st_down_elbow;
            end
            st_down_elbow:
            begin
                if (dwell_end)
                    state_next = st_close_claw;
            end
            st_close_claw:
            begin
                if (dwell_end)
                    state_next = st_up_elbow;
            end
            st_up_elbow:
            begin
                if (dwell_end)
                    state_next = claw_closed ? st_deliver_waist : st_wait;
            end
            st_deliver_waist:
            begin
                if (dwell_end)
                    state_next = st_deliver_elbow;
            end
            st_deliver_elbow:
            begin
                if (dwell_end)
                    state_next = st_open_claw;
            end
            st_open_claw:
            begin
                if (dwell_end)
                    state_next = st_up_elbow;
            end
            default: state_next = st_wait;
        endcase
    end

    always_ff @(posedge clk or posedge clr)
    begin
        if (clr)
        begin
            state       <= st_wait;
            dwell_cnt   <= '0;
            served      <= '0;
            claw_closed <= 1'b0;
        end
        else
        begin
            state <= state_next;

            // restart on entry, and in st_start when no beacon is seen
            if (state == st_wait || state_next != state || dwell_end)
                dwell_cnt <= '0;
            else if (servo.frame_end)
                dwell_cnt <= dwell_cnt + 1'b1;

            if (state == st_close_claw && dwell_end)
                claw_closed <= 1'b1;
            else if (state == st_open_claw && dwell_end)
            begin
                claw_closed <= 1'b0;
                served      <= served | ir;   // every beacon seen on release
            end
        end
    end

    // pose table, one clock behind the state
    always_ff @(posedge clk or posedge clr)
    begin
        if (clr)
        begin
            servo.waist <= W_WAIST_HOME;
            servo.elbow <= W_ELBOW_HOME;
            servo.claw  <= W_CLAW_OPEN;
        end
        else
        begin
            case (state)
                st_wait, st_start:
                begin
                    servo.waist <= W_WAIST_HOME;
                    servo.elbow <= W_ELBOW_HOME;
                    servo.claw  <= W_CLAW_OPEN;
                end
                st_left_waist:
                begin
                    servo.waist <= W_WAIST_LEFT;
                    servo.elbow <= W_ELBOW_RAISED;
                    servo.claw  <= W_CLAW_OPEN;
                end
                st_right_waist:
                begin
                    servo.waist <= W_WAIST_RIGHT;
                    servo.elbow <= W_ELBOW_RAISED;
                    servo.claw  <= W_CLAW_OPEN;
                end
                st_middle_waist:  servo.waist <= W_WAIST_MIDDLE;
                st_down_elbow:    servo.elbow <= W_ELBOW_DOWN;
                st_close_claw:    servo.claw  <= W_CLAW_CLOSED;
                st_up_elbow:      servo.elbow <= W_ELBOW_UP;
                st_open_claw:     servo.claw  <= W_CLAW_OPEN;
                st_deliver_waist: servo.waist <= W_WAIST_DELIVER;
                st_deliver_elbow: servo.elbow <= W_ELBOW_DELIVER;
                default: ;   // settle holds the pose
            endcase
        end
    end

    a_state_legal: assert property (@(posedge clk) disable iff (clr)
        state inside {st_wait, st_start, st_right_waist, st_left_waist,
                      st_middle_waist, st_down_elbow, st_up_elbow,
                      st_deliver_waist, st_close_claw, st_open_claw,
                      st_deliver_elbow, st_settle})
        else $error("illegal arm state %0d", state);

    // the dwell count relies on one pulse per frame
    a_frame_pulse: assert property (@(posedge clk) disable iff (clr)
        servo.frame_end |=> !servo.frame_end)
        else $error("frame_end high on consecutive clocks");

endmodule

// File: src/servo_pwm.sv
`timescale 1ns/1ps

module servo_pwm import arm_pkg::*; #(
    parameter int tick_div = DEF_TICK_DIV
) (
    input  logic clk,
    input  logic clr,
    servo_if.pwm servo,
    output logic pwm_waist,
    output logic pwm_elbow,
    output logic pwm_claw
);

    logic [$clog2(tick_div + 1) - 1:0] pre_cnt;   // clocks within a step
    logic                              step;
    servo_width_t                      step_cnt;  // steps within a frame

    assign step = (pre_cnt == $bits(pre_cnt)'(tick_div - 1));

    always_ff @(posedge clk or posedge clr)
    begin
        if (clr)
        begin
            pre_cnt  <= '0;
            step_cnt <= '0;
        end
        else
        begin
            if (step)
            begin
                pre_cnt <= '0;
                if (step_cnt == servo_width_t'(PWM_FRAME_STEPS - 1))
                    step_cnt <= '0;
                else
                    step_cnt <= step_cnt + 1'b1;
            end
            else
                pre_cnt <= pre_cnt + 1'b1;
        end
    end

    assign servo.frame_end = step && (step_cnt == servo_width_t'(PWM_FRAME_STEPS - 1));

    // high for the first width steps of every frame
    assign pwm_waist = (step_cnt < servo.waist);
    assign pwm_elbow = (step_cnt < servo.elbow);
    assign pwm_claw  = (step_cnt < servo.claw);

    a_width_range: assert property (@(posedge clk) disable iff (clr)
        servo.waist < servo_width_t'(PWM_FRAME_STEPS) &&
        servo.elbow < servo_width_t'(PWM_FRAME_STEPS) &&
        servo.claw  < servo_width_t'(PWM_FRAME_STEPS))
        else $error("servo width beyond frame length");

endmodule

// File: src/state_display.sv
`timescale 1ns/1ps

module state_display import arm_pkg::*; #(
    parameter int scan_bits = DEF_SCAN_BITS
) (
    input  logic       clk,
    input  logic       clr,
    input  arm_state_t state,
    output logic [7:0] sevseg,
    output logic [3:0] an
);

    logic [scan_bits-1:0] scan_cnt;   // free running
    logic [1:0]           digit;
    logic [3:0]           code;
    logic [6:0]           glyph;

    always_ff @(posedge clk or posedge clr)
    begin
        if (clr)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    assign digit = scan_cnt[scan_bits-1 -: 2];   // top two bits pick the digit
    assign code  = state;

    always_comb
    begin
        case (digit)
            2'd0:    an = 4'b1110;   // rightmost
            2'd1:    an = 4'b1101;
            2'd2:    an = 4'b1011;
            default: an = 4'b0111;
        endcase
    end

    // only the rightmost digit carries the code
    always_comb
    begin
        glyph = GLYPH_DASH;
        if (digit == 2'd0 && code < 4'(NUM_GLYPHS))
            glyph = GLYPH_HEX[code];
    end

    assign sevseg = {1'b1, glyph};   // decimal point off

endmodule

// File: src/arm_top.sv
`timescale 1ns/1ps

module arm_top import arm_pkg::*; #(
    parameter int tick_div     = DEF_TICK_DIV,
    parameter int dwell_frames = DEF_DWELL_FRAMES,
    parameter int scan_bits    = DEF_SCAN_BITS
) (
    input  logic       clk,
    input  logic       clr,
    input  logic [2:0] ir,       // beacon select, bit 0 left, 1 right, 2 middle
    input  logic       ir_arm,   // beacon seen
    output logic       pwm_waist,
    output logic       pwm_elbow,
    output logic       pwm_claw,
    output logic [7:0] sevseg,
    output logic [3:0] an
);

    servo_if    servo ();
    arm_state_t state;

    arm_sequencer #(.dwell_frames(dwell_frames)) arm_sequencer_inst (
        .clk    (clk),
        .clr    (clr),
        .ir     (ir),
        .ir_arm (ir_arm),
        .servo  (servo.seq),
        .state  (state)
    );

    servo_pwm #(.tick_div(tick_div)) servo_pwm_inst (
        .clk       (clk),
        .clr       (clr),
        .servo     (servo.pwm),
        .pwm_waist (pwm_waist),
        .pwm_elbow (pwm_elbow),
        .pwm_claw  (pwm_claw)
    );

    state_display #(.scan_bits(scan_bits)) state_display_inst (
        .clk    (clk),
        .clr    (clr),
        .state  (state),
        .sevseg (sevseg),
        .an     (an)
    );

endmodule

// File: test/arm_model.svh
// served beacons and current pose, as the testbench expects them
logic [2:0] served_model;
int         pose_waist;
int         pose_elbow;
int         pose_claw;
int         exp_path[$];   // display codes expected during one visit

function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// active low gfedcba, -1 for anything that is not a state digit
function automatic int glyph_code(input logic [6:0] seg);
    case (seg)
        7'b1000000: return 0;
        7'b1111001: return 1;
        7'b0100100: return 2;
        7'b0110000: return 3;
        7'b0011001: return 4;
        7'b0010010: return 5;
        7'b0000010: return 6;
        7'b1111000: return 7;
        7'b0000000: return 8;
        7'b0010000: return 9;
        7'b0001000: return 10;
        7'b0000011: return 11;
        7'b1000110: return 12;
        default:    return -1;
    endcase
endfunction

// joints a state leaves alone keep their last width
function automatic void apply_pose(input int code);
    case (code)
        0, 1:
        begin
            pose_waist = W_WAIST_HOME;
            pose_elbow = W_ELBOW_HOME;
            pose_claw  = W_CLAW_OPEN;
        end
        3:
        begin
            pose_waist = W_WAIST_LEFT;
            pose_elbow = W_ELBOW_RAISED;
            pose_claw  = W_CLAW_OPEN;
        end
        2:
        begin
            pose_waist = W_WAIST_RIGHT;
            pose_elbow = W_ELBOW_RAISED;
            pose_claw  = W_CLAW_OPEN;
        end
        4:  pose_waist = W_WAIST_MIDDLE;
        5:  pose_elbow = W_ELBOW_DOWN;
        8:  pose_claw  = W_CLAW_CLOSED;
        6:  pose_elbow = W_ELBOW_UP;
        9:  pose_claw  = W_CLAW_OPEN;
        7:  pose_waist = W_WAIST_DELIVER;
        11: pose_elbow = W_ELBOW_DELIVER;
        default: ;   // settle
    endcase
endfunction

// code sequence of one request, served flags updated on delivery
function automatic void build_path(input logic [2:0] bits);
    int tgt;
    exp_path.delete();
    exp_path.push_back(1);
    tgt = bits[0] ? 0 : (bits[1] ? 1 : 2);
    if (served_model[tgt])
    begin
        exp_path.push_back(0);   // refused at once
        return;
    end
    case (tgt)
        0:       exp_path = {exp_path, 3, 12};
        1:       exp_path = {exp_path, 2, 12};
        default: exp_path.push_back(4);
    endcase
    exp_path = {exp_path, 5, 8, 6, 7, 11, 9, 6, 0};
    served_model = served_model | bits;   // every bit held through the release
endfunction

// File: test/tb_arm_top.sv
`timescale 1ns/1ps

module tb_arm_top import arm_pkg::*; ();

    localparam int     RANDOM_VISITS = 12;
    localparam int     TOTAL_VISITS  = RANDOM_VISITS + 1 + 2 * NUM_TARGETS;
    localparam longint TIMEOUT_NS    = longint'(TOTAL_VISITS) * 14 * 2 * PWM_FRAME_STEPS * 10
                                       + 200_000;

    logic       clk;
    logic       clr;
    logic [2:0] ir;
    logic       ir_arm;
    logic       pwm_waist;
    logic       pwm_elbow;
    logic       pwm_claw;
    logic [7:0] sevseg;
    logic [3:0] an;

    logic [31:0] rnd;
    logic [2:0]  bits;
    int          visit_no;
    int          codes[$];        // display code changes as seen
    int          last_code = -1;
    logic [3:0]  prev_an = 4'b1110;
    int          cyc;             // clocks since reset, mirrors the step count
    logic        started = 1'b0;
    int          phase;
    int          hi_waist;
    int          hi_elbow;
    int          hi_claw;
    logic        frame_full = 1'b0;
    int          frames_checked = 0;

    `include "arm_model.svh"

    arm_top #(.tick_div(1), .dwell_frames(2), .scan_bits(4)) arm_top_inst (
        .clk       (clk),
        .clr       (clr),
        .ir        (ir),
        .ir_arm    (ir_arm),
        .pwm_waist (pwm_waist),
        .pwm_elbow (pwm_elbow),
        .pwm_claw  (pwm_claw),
        .sevseg    (sevseg),
        .an        (an)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check(input string name, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("** Error: %s expected %0d actual %0d", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    // one ir_arm strobe, launched at the start of digit 0 so a short st_start shows
    task automatic run_visit(input logic [2:0] req);
        int k;
        build_path(req);
        while (an == 4'b1110)
            @(negedge clk);
        while (an != 4'b1110)
            @(negedge clk);
        codes.delete();
        ir     = req;
        ir_arm = 1'b1;
        @(negedge clk);
        ir_arm = 1'b0;
        while (codes.size() == 0 || codes[$] != 0)
            @(negedge clk);
        ir = 3'b000;
        check($sformatf("visit %0d path length", visit_no), exp_path.size(), codes.size());
        for (k = 0; k < exp_path.size(); k++)
            check($sformatf("visit %0d code %0d", visit_no, k), exp_path[k], codes[k]);
        visit_no++;
    endtask

    always @(posedge clk)
    begin
        cyc     <= clr ? 0 : cyc + 1;
        started <= !clr;
    end

    // display decode and scan order
    always @(negedge clk)
    begin
        check("decimal point", 1, sevseg[7]);
        if (!(an inside {4'b1110, 4'b1101, 4'b1011, 4'b0111}))
            report_failure("anode select is not one-hot low");
        if (an != prev_an)
            check("anode order", {prev_an[2:0], prev_an[3]}, an);
        if (an == 4'b1110)
        begin
            if (glyph_code(sevseg[6:0]) < 0)
                report_failure("state digit shows a pattern that is no glyph");
            else if (glyph_code(sevseg[6:0]) != last_code)
            begin
                last_code = glyph_code(sevseg[6:0]);
                codes.push_back(last_code);
                apply_pose(last_code);
            end
        end
        else
            check("dash on upper digit", GLYPH_DASH, sevseg[6:0]);
        prev_an = an;
    end

    // high time of each output over whole frames
    always @(negedge clk)
    begin
        if (started)
        begin
            phase = cyc % PWM_FRAME_STEPS;
            if (phase == 0)
            begin
                hi_waist   = 0;
                hi_elbow   = 0;
                hi_claw    = 0;
                frame_full = 1'b1;
            end
            hi_waist += pwm_waist;
            hi_elbow += pwm_elbow;
            hi_claw  += pwm_claw;
            if (phase == PWM_FRAME_STEPS - 1 && frame_full)
            begin
                check($sformatf("waist width in state %0d", last_code), pose_waist, hi_waist);
                check($sformatf("elbow width in state %0d", last_code), pose_elbow, hi_elbow);
                check($sformatf("claw width in state %0d", last_code), pose_claw, hi_claw);
                frames_checked++;
            end
        end
    end

    initial
    begin
        #(TIMEOUT_NS);
        report_failure("watchdog expired before the visits completed");
    end

    initial
    begin
        clr          = 1'b1;
        ir           = 3'b000;
        ir_arm       = 1'b0;
        rnd          = 32'h40de_cdad;
        visit_no     = 0;
        served_model = 3'b000;
        apply_pose(0);
        repeat (16) @(negedge clk);
        clr = 1'b0;

        while (frames_checked < 1)   // home pose over a full frame
            @(negedge clk);
        check("codes after reset", 1, codes.size());
        check("code after reset", 0, codes[0]);

        // right wins over middle, both served on release
        run_visit(3'b110);

        repeat (RANDOM_VISITS)
        begin
            rnd = xorshift(rnd);
            if (rnd[12:11] == 2'd0 && rnd[2:0] != 3'b000)
                bits = rnd[2:0];   // several beacons at once
            else
                bits = 3'b001 << (rnd[9:8] % 3);
            run_visit(bits);
        end

        // first sweep serves what is left, second sees only refusals
        repeat (2)
        begin
            run_visit(3'b001);
            run_visit(3'b010);
            run_visit(3'b100);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: sources.f
+incdir+test
src/arm_pkg.sv
src/servo_if.sv
src/arm_sequencer.sv
src/servo_pwm.sv
src/state_display.sv
src/arm_top.sv
test/tb_arm_top.sv
